// ==== hdl/fetch_cfg.svh ====
/*
 * fetch front end configuration
 * address width, instruction memory size and the fixed memory latency
 * shared by the packages and the memory model
 */
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// byte address width of the machine
`define FETCH_ADDR_W 64

// instruction memory, counted in 64-bit words (two instructions each)
`define IMEM_WORDS 256

// extra cycles memory waits after an address change before answering
`define IMEM_LAT 2

// word index width, follows from the depth
`define IMEM_IDX_W $clog2(`IMEM_WORDS)

`endif

// ==== hdl/isa_pkg.sv ====
/*
 * architectural types of the teaching processor
 * byte address, 64-bit memory word and 32-bit instruction
 */
`include "fetch_cfg.svh"

package isa_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  localparam int ADDR_W     = `FETCH_ADDR_W; // byte address
  localparam int INST_W     = 32;            // one instruction
  localparam int INST_BYTES = INST_W / 8;    // pc step between instructions

  //////////////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////////////

  // byte address, fetch requests keep the low three bits clear
  typedef logic [ADDR_W-1:0] addr_t;

  // one instruction as stored in memory
  typedef logic [INST_W-1:0] inst_t;

  // memory word holding two instructions
  // index 0 is the lower half (pc bit 2 clear), index 1 the upper half
  typedef logic [1:0][INST_W-1:0] mem_word_t;

endpackage

// ==== hdl/fetch_pkg.sv ====
/*
 * structs passed between the fetch stage, the instruction memory
 * and the back end
 */
package fetch_pkg;
  import isa_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // memory side
  //////////////////////////////////////////////////////////////////////

  // fetch request, word aligned (8 bytes)
  typedef struct packed {
    addr_t addr;
  } imem_req_t;

  // memory answer, valid is a level
  typedef struct packed {
    logic      valid; // word at the requested address is ready
    mem_word_t data;
  } imem_rsp_t;

  // preload write port, one word per cycle while in reset
  typedef struct packed {
    logic      en;
    addr_t     addr;  // word aligned
    mem_word_t data;
  } imem_load_t;

  //////////////////////////////////////////////////////////////////////
  // back end side
  //////////////////////////////////////////////////////////////////////

  // retire report, valid is a one-cycle strobe
  typedef struct packed {
    logic  valid;
    logic  branch;  // retired instruction is a branch
    logic  taken;   // and it was taken
    addr_t target;  // redirect pc
  } retire_t;

  // one issued instruction
  typedef struct packed {
    logic  valid;
    addr_t pc;
    addr_t npc;     // pc + 4
    inst_t inst;
  } fetch_packet_t;

endpackage

// ==== hdl/imem.sv ====
/*
 * instruction memory model
 * array of 64-bit words filled through a preload port during reset
 * and read by word index; the answer is held back until the request
 * address has been stable for IMEM_LAT+1 edges, like the lab bus
 */
`include "fetch_cfg.svh"

module imem (
  input  logic                  clock,
  input  logic                  reset,
  input  fetch_pkg::imem_load_t load,
  input  fetch_pkg::imem_req_t  req,
  output fetch_pkg::imem_rsp_t  rsp
);
  import isa_pkg::*;

  localparam int IDX_W = `IMEM_IDX_W;
  localparam int CNT_W = $clog2(`IMEM_LAT + 2);   // room for 0..IMEM_LAT
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`IMEM_LAT);

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  mem_word_t mem [0:`IMEM_WORDS-1];

  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;

  assign wr_idx = load.addr[IDX_W+2:3];  // drop byte offset in the word
  assign rd_idx = req.addr[IDX_W+2:3];

  // preload write, one word per cycle
  always_ff @(posedge clock) begin
    if (load.en) begin
      mem[wr_idx] <= load.data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // latency tracking
  //////////////////////////////////////////////////////////////////////

  addr_t            last_addr;  // address seen at the last edge
  logic             tracking;   // last_addr holds a real request
  logic [CNT_W-1:0] wait_cnt;   // edges since the address settled
  logic             addr_same;

  // reset acts like an address change, so the first answer also
  // takes IMEM_LAT+1 edges
  assign addr_same = tracking && (req.addr == last_addr);

  always_ff @(posedge clock) begin
    if (reset) begin
      tracking  <= 1'b0;
      last_addr <= '0;
      wait_cnt  <= '0;
    end else if (!addr_same) begin
      tracking  <= 1'b1;       // new address, restart the wait
      last_addr <= req.addr;
      wait_cnt  <= '0;
    end else if (wait_cnt != CNT_MAX) begin
      wait_cnt  <= wait_cnt + 1'b1;  // saturates at IMEM_LAT
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rsp.valid = addr_same && (wait_cnt == CNT_MAX);  // stays up while addr holds
    rsp.data  = mem[rd_idx];                         // combinational read
  end

endmodule

// ==== hdl/fetch_stage.sv ====
/*
 * instruction fetch stage
 * keeps the pc, asks memory for the word around it, picks the
 * instruction half from pc bit 2 and issues it to the back end
 * only one instruction is in flight; the next one waits for retire
 */
module fetch_stage (
  input  logic                     clock,
  input  logic                     reset,
  input  fetch_pkg::imem_rsp_t     imem_rsp,
  input  fetch_pkg::retire_t       retire,
  input  logic                     dispatch_en,
  output fetch_pkg::imem_req_t     imem_req,
  output fetch_pkg::fetch_packet_t fetch_out
);
  import isa_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // state and next-state signals
  //////////////////////////////////////////////////////////////////////

  addr_t pc;          // pc being fetched
  logic  ready;       // nothing in flight, may issue
  addr_t pc_plus_4;
  addr_t next_pc;
  logic  issue;       // instruction leaves this cycle
  logic  redirect;    // retire of a taken branch
  logic  pc_load;
  logic  next_ready;

  //////////////////////////////////////////////////////////////////////
  // next pc selection
  //////////////////////////////////////////////////////////////////////

  assign pc_plus_4 = pc + addr_t'(INST_BYTES);

  // all three bits must be set, branch alone or taken alone is ignored
  assign redirect = retire.valid && retire.branch && retire.taken;

  // redirect wins over the sequential step
  assign next_pc = redirect ? retire.target : pc_plus_4;
  assign pc_load = redirect || issue;  // pc holds otherwise

  //////////////////////////////////////////////////////////////////////
  // one-in-flight gate
  //////////////////////////////////////////////////////////////////////

  // issue and retire never share a cycle while one is in flight
  assign issue      = ready && imem_rsp.valid && dispatch_en;
  assign next_ready = (ready || retire.valid) && !issue;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc    <= '0;    // fetch starts at address 0
      ready <= 1'b1;
    end else begin
      ready <= next_ready;
      if (pc_load) begin
        pc <= next_pc;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // memory request and issue packet
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    imem_req.addr = {pc[ADDR_W-1:3], 3'b000};  // word aligned
  end

  always_comb begin
    fetch_out.valid = issue;
    fetch_out.pc    = pc;
    fetch_out.npc   = pc_plus_4;
    fetch_out.inst  = imem_rsp.data[pc[2]];   // upper half when bit 2 set
  end

endmodule

// ==== hdl/fetch_top.sv ====
/*
 * fetch front end top level
 * fetch stage wired to the instruction memory model; the back end
 * drives dispatch enable and the retire reports from outside
 */
module fetch_top (
  input  logic                     clock,
  input  logic                     reset,
  input  fetch_pkg::imem_load_t    load,
  input  fetch_pkg::retire_t       retire,
  input  logic                     dispatch_en,
  output fetch_pkg::fetch_packet_t fetch_out
);
  import fetch_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // fetch stage <-> memory
  //////////////////////////////////////////////////////////////////////

  imem_req_t imem_req;  // current pc, word aligned
  imem_rsp_t imem_rsp;  // word plus valid level

  // pc, ready flop and instruction select
  fetch_stage u_fetch_stage (
    .clock       (clock),
    .reset       (reset),
    .imem_rsp    (imem_rsp),
    .retire      (retire),
    .dispatch_en (dispatch_en),
    .imem_req    (imem_req),
    .fetch_out   (fetch_out)
  );

  // memory with fixed latency after each address change
  imem u_imem (
    .clock (clock),
    .reset (reset),
    .load  (load),       // preload only while reset is high
    .req   (imem_req),
    .rsp   (imem_rsp)
  );

endmodule

// ==== test/fetch_tb.sv ====
/*
 * testbench for the fetch front end
 * preloads memory with random words during reset, plays the back end
 * with random dispatch enable and retire reports, and checks each
 * cycle against a cycle model of the fetch rules
 */
`include "fetch_cfg.svh"

module fetch_tb;
  import isa_pkg::*;
  import fetch_pkg::*;

  localparam int IDX_W     = `IMEM_IDX_W;
  localparam int LAT       = `IMEM_LAT;
  localparam int RESET_CYC = 8;     // quiet reset cycles after the preload
  localparam int RUN_CYC   = 3000;  // random back-end cycles
  localparam int DISP_PCT  = 70;    // dispatch enable probability, percent
  localparam int N_TESTS   = 5;
  localparam longint TIMEOUT =
    longint'(`IMEM_WORDS + RESET_CYC + RUN_CYC) * (LAT + 10) * 100;

  ////////////////////////////////////////////////////////////////////////
  // DUT and clock
  ////////////////////////////////////////////////////////////////////////

  logic          clock       = 1'b0;
  logic          reset       = 1'b1;
  imem_load_t    load        = '0;
  retire_t       retire      = '0;
  logic          dispatch_en = 1'b1;  // high until the first issue
  fetch_packet_t fetch_out;

  fetch_top uut (
    .clock       (clock),
    .reset       (reset),
    .load        (load),
    .retire      (retire),
    .dispatch_en (dispatch_en),
    .fetch_out   (fetch_out)
  );

  always #50 clock = ~clock;  // period 100

  ////////////////////////////////////////////////////////////////////////
  // results and compare tasks
  ////////////////////////////////////////////////////////////////////////

  mem_word_t mem_copy [0:`IMEM_WORDS-1];  // what went into memory
  int        n_checks [1:N_TESTS];
  int        n_errors [1:N_TESTS];
  int        n_other;                     // failures that are not a wrong value
  string     test_name [1:N_TESTS] = '{"reset state", "sequential fetch",
                                       "one in flight", "redirect", "back-pressure"};

  task automatic check_packet(input int t, input string what,
                              input fetch_packet_t got, input fetch_packet_t exp);
    n_checks[t]++;
    if (got !== exp) begin
      n_errors[t]++;
      $display("CHECK FAILED at %0t: test %0d %s, got %h expected %h",
               $time, t, what, got, exp);
    end
  endtask

  task automatic check_addr(input int t, input string what,
                            input addr_t got, input addr_t exp);
    n_checks[t]++;
    if (got !== exp) begin
      n_errors[t]++;
      $display("CHECK FAILED at %0t: test %0d %s, got %h expected %h",
               $time, t, what, got, exp);
    end
  endtask

  task automatic check_flag(input int t, input string what, input logic got, input logic exp);
    n_checks[t]++;
    if (got !== exp) begin
      n_errors[t]++;
      $display("CHECK FAILED at %0t: test %0d %s, got %b expected %b",
               $time, t, what, got, exp);
    end
  endtask

  // exact cycle count
  task automatic check_cycles(input int t, input string what, input int got, input int exp);
    n_checks[t]++;
    if (got != exp) begin
      n_errors[t]++;
      $display("CHECK FAILED at %0t: test %0d %s, got %0d expected %0d",
               $time, t, what, got, exp);
    end
  endtask

  // lower bound on a cycle count
  task automatic check_min_cycles(input int t, input string what, input int got, input int lo);
    n_checks[t]++;
    if (got < lo) begin
      n_errors[t]++;
      $display("CHECK FAILED at %0t: test %0d %s, got %0d expected at least %0d",
               $time, t, what, got, lo);
    end
  endtask

  task automatic report_test(input int t);
    $display("test %0d %s: %0d checks, %0d errors", t, test_name[t], n_checks[t], n_errors[t]);
  endtask

  ////////////////////////////////////////////////////////////////////////
  // reference model, checks and back-end stimulus
  ////////////////////////////////////////////////////////////////////////

  addr_t m_pc;           // expected pc
  logic  m_ready;        // expected ready
  int    m_since;        // edges since the fetch word last changed
  int    rel_cyc;        // cycles since reset release
  int    reset_edges;
  bit    first_seen;
  bit    in_flight;
  addr_t last_issue_pc;
  int    retire_wait;    // cycles to the next retire strobe, 0 idle
  bit    pend_valid;     // a retire fixed the next issued pc
  addr_t pend_pc;
  int    pend_test;
  bit    gap_pending;    // redirect moved to another memory word
  int    retire_cyc;
  bit    stalled;        // dispatch held low while ready
  addr_t stall_pc;

  // samples at the edge, so everything seen belongs to the cycle just ended
  always @(posedge clock) begin
    fetch_packet_t got;
    fetch_packet_t exp;
    retire_t       r;
    logic          exp_issue;
    logic          redirect;
    addr_t         next_pc;
    mem_word_t     word;
    int            t_valid;

    got = fetch_out;
    if (reset) begin
      reset_edges++;
      if (reset_edges > 1) begin  // flops are unknown before the first edge
        check_flag(1, "valid during reset", got.valid, 1'b0);
      end
      m_pc        = '0;
      m_ready     = 1'b1;
      m_since     = 0;      // release acts as a word change
      rel_cyc     = 0;
      in_flight   = 1'b0;
      retire_wait = 0;
      dispatch_en <= 1'b1;
      retire      <= '0;
    end else begin
      exp_issue = m_ready && dispatch_en && (m_since > LAT);  // word stable LAT+1 edges
      redirect  = retire.valid && retire.branch && retire.taken;
      word      = mem_copy[m_pc[IDX_W+2:3]];
      t_valid   = !dispatch_en ? 5 : (in_flight ? 3 : 2);

      check_flag(t_valid, "issue valid", got.valid, exp_issue);
      check_addr(2, "fetch pc", got.pc, m_pc);
      if (exp_issue) begin
        exp.valid = 1'b1;
        exp.pc    = m_pc;
        exp.npc   = m_pc + addr_t'(4);
        exp.inst  = word[m_pc[2]];  // pc bit 2 picks the upper half
        check_packet(2, "issued packet", got, exp);
      end

      if (got.valid) begin
        if (!first_seen) begin
          first_seen = 1'b1;
          check_addr(1, "first pc", got.pc, '0);
          check_cycles(1, "cycles to first issue", rel_cyc, LAT + 1);
          report_test(1);
        end
        if (pend_valid) begin
          check_addr(pend_test, "pc after retire", got.pc, pend_pc);
          pend_valid = 1'b0;
        end
        if (gap_pending) begin
          check_min_cycles(3, "retire to issue", rel_cyc - retire_cyc, LAT + 2);
          gap_pending = 1'b0;
        end
        if (stalled) begin
          check_addr(5, "pc after stall", got.pc, stall_pc);
          stalled = 1'b0;
        end
        in_flight     = 1'b1;
        last_issue_pc = m_pc;
        retire_wait   = $urandom_range(1, 6);
      end

      if (retire.valid) begin
        in_flight   = 1'b0;
        pend_valid  = 1'b1;
        pend_pc     = redirect ? retire.target : last_issue_pc + addr_t'(4);
        pend_test   = (retire.branch || retire.taken) ? 4 : 2;
        gap_pending = redirect && (retire.target[ADDR_W-1:3] != m_pc[ADDR_W-1:3]);
        retire_cyc  = rel_cyc;
      end

      if (!dispatch_en && m_ready && !stalled) begin
        stalled  = 1'b1;
        stall_pc = m_pc;
      end

      // advance the model by one edge
      next_pc = m_pc;
      if (redirect) begin
        next_pc = retire.target;  // wins over the step
      end else if (exp_issue) begin
        next_pc = m_pc + addr_t'(4);
      end
      if (exp_issue) begin
        m_ready = 1'b0;
      end else if (retire.valid) begin
        m_ready = 1'b1;
      end
      if (next_pc[ADDR_W-1:3] != m_pc[ADDR_W-1:3]) begin
        m_since = 0;
      end else if (m_since <= LAT) begin
        m_since++;
      end
      m_pc = next_pc;
      rel_cyc++;

      // inputs for the next cycle
      if (!first_seen) begin
        dispatch_en <= 1'b1;
      end else begin
        dispatch_en <= ($urandom_range(0, 99) < DISP_PCT);
      end
      if (retire_wait == 1) begin
        r.valid  = 1'b1;
        r.branch = 1'($urandom_range(0, 1));
        r.taken  = 1'($urandom_range(0, 1));
        r.target = addr_t'($urandom_range(0, 2 * `IMEM_WORDS - 1)) << 2;  // inside memory
        retire <= r;
        retire_wait = 0;
      end else begin
        if (retire_wait > 1) begin
          retire_wait--;
        end
        retire <= '0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // run control
  ////////////////////////////////////////////////////////////////////////

  initial begin
    mem_word_t  w;
    imem_load_t ld;
    int         total_checks;
    int         total_errors;

    void'($urandom(32'h9058b08a));
    // reset stays high through the preload, one word per cycle
    for (int i = 0; i < `IMEM_WORDS; i++) begin
      @(posedge clock);
      w           = {$urandom(), $urandom()};
      mem_copy[i] = w;
      ld.en       = 1'b1;
      ld.addr     = addr_t'(i) << 3;
      ld.data     = w;
      load <= ld;
    end
    @(posedge clock);
    load <= '0;
    repeat (RESET_CYC) @(posedge clock);
    reset <= 1'b0;
    repeat (RUN_CYC) @(posedge clock);
    @(negedge clock);

    if (!first_seen) begin
      n_other++;
      $display("no instruction was issued after reset");
    end
    total_checks = 0;
    total_errors = 0;
    for (int t = 1; t <= N_TESTS; t++) begin
      if (t > 1 || !first_seen) begin
        report_test(t);
      end
      if (n_checks[t] == 0) begin
        n_other++;
        $display("test %0d %s was never exercised", t, test_name[t]);
      end
      total_checks += n_checks[t];
      total_errors += n_errors[t];
    end
    $display("totals: %0d checks, %0d wrong values, %0d other failures",
             total_checks, total_errors, n_other);
    if (total_errors == 0 && n_other == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // watchdog, generous bound per run cycle
  initial begin
    #(TIMEOUT);
    $display("TIMEOUT: the run did not finish within %0d time units", TIMEOUT);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+hdl
hdl/isa_pkg.sv
hdl/fetch_pkg.sv
hdl/imem.sv
hdl/fetch_stage.sv
hdl/fetch_top.sv
test/fetch_tb.sv

// ==== Makefile ====
# Verilator build and run of the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then \
		echo "simulation reported failures, see $(LOG)"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || \
		(echo "simulation ended without a result, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
